// File: dv/rv_ctrl_props.sv
module rv_ctrl_props (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall_o,
    input rv_ctrl_pkg::seq_state_e state_q,
    input rv_ctrl_pkg::wb_t       wb_o
);

    // a load stalls exactly one cycle
    a_stall_single: assert property (@(posedge clk) disable iff (!rst)
        stall_o |=> !stall_o)
        else $error("stall held for two cycles");

    // wb state only entered from a stalled load
    a_wb_after_stall: assert property (@(posedge clk) disable iff (!rst)
        (state_q == rv_ctrl_pkg::ST_WB) |-> $past(stall_o))
        else $error("wb state without preceding stall");

    // x0 is never a write target
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst)
        wb_o.reg_we |-> (wb_o.rd != '0))
        else $error("register write enabled with rd zero");

endmodule

bind mem_seq rv_ctrl_props i_rv_ctrl_props (
    .clk     (clk),
    .rst     (rst),
    .stall_o (stall_o),
    .state_q (state_q),
    .wb_o    (wb_o)
);

// File: dv/rv_ctrl_tb.sv
module rv_ctrl_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 16;
    // instructions applied after reset
    localparam int N_TEST_INSNS = 142;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic clk;
    logic rst;
    rv_ctrl_pkg::insn_u instr;
    logic eq, lt, ltu;
    logic [rv_ctrl_pkg::REG_AW-1:0] rs1, rs2;
    logic [rv_ctrl_pkg::XLEN-1:0] imm;
    rv_ctrl_pkg::ctrl_t ctrl;
    rv_ctrl_pkg::wb_t wb;
    rv_ctrl_pkg::mem_size_e size;
    rv_ctrl_pkg::crypto_t crypto;
    logic sys, stall;
    logic [31:0] rng_state = 32'h61e8;

    rv_ctrl i_rv_ctrl (
        .clk      (clk),
        .rst      (rst),
        .instr_i  (instr),
        .eq_i     (eq),
        .lt_i     (lt),
        .ltu_i    (ltu),
        .rs1_o    (rs1),
        .rs2_o    (rs2),
        .imm_o    (imm),
        .ctrl_o   (ctrl),
        .wb_o     (wb),
        .size_o   (size),
        .crypto_o (crypto),
        .sys_o    (sys),
        .stall_o  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard limit on run length
    initial begin
        #((N_TEST_INSNS * 40 + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "check error");
    endtask

    task automatic check_ctrl(input string n, input rv_ctrl_pkg::ctrl_t got,
                              input rv_ctrl_pkg::ctrl_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, n, got, exp));
        end
    endtask

    task automatic check_wb(input string n, input rv_ctrl_pkg::wb_t got,
                            input rv_ctrl_pkg::wb_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, n, got, exp));
        end
    endtask

    task automatic check_crypto(input string n, input rv_ctrl_pkg::crypto_t got,
                                input rv_ctrl_pkg::crypto_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, n, got, exp));
        end
    endtask

    task automatic check_word(input string n, input logic [rv_ctrl_pkg::XLEN-1:0] got,
                              input logic [rv_ctrl_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, n, got, exp));
        end
    endtask

    task automatic check_size(input string n, input rv_ctrl_pkg::mem_size_e got,
                              input rv_ctrl_pkg::mem_size_e exp);
        if (got !== exp) begin
            fail_stop($sformatf("CHECK FAILED t=%0t %s got=%0d exp=%0d", $time, n, got, exp));
        end
    endtask

    // new inputs on the falling edge, outputs sampled 1 unit later
    task automatic drive(input logic [31:0] w, input logic [2:0] flags);
        @(negedge clk);
        instr = w;
        {eq, lt, ltu} = flags;
        #1;
    endtask

    function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [4:0] r2,
                                           input logic [4:0] r1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, r2, r1, f3, rd, opc};
    endfunction

    // standard riscv immediate layouts
    function automatic logic [31:0] imm_i(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] imm_b(input logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic rv_ctrl_pkg::alu_func_e exp_alu(input logic [2:0] f3, input logic b30,
                                                       input logic r_type);
        case (f3)
            3'd0: return (r_type && b30) ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            3'd1: return rv_ctrl_pkg::ALU_SLL;
            3'd2: return rv_ctrl_pkg::ALU_SLT;
            3'd3: return rv_ctrl_pkg::ALU_SLTU;
            3'd4: return rv_ctrl_pkg::ALU_XOR;
            3'd5: return b30 ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'd6: return rv_ctrl_pkg::ALU_OR;
            default: return rv_ctrl_pkg::ALU_AND;
        endcase
    endfunction

    // flags are {eq, lt, ltu}
    function automatic logic exp_taken(input logic [2:0] f3, input logic [2:0] fl);
        case (f3)
            3'd0: return fl[2];
            3'd1: return !fl[2];
            3'd4: return fl[1];
            3'd5: return !fl[1];
            3'd6: return fl[0];
            3'd7: return !fl[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_ctrl_pkg::mem_size_e exp_size(input logic [2:0] f3);
        case (f3)
            3'd1: return rv_ctrl_pkg::SZ_H;
            3'd2: return rv_ctrl_pkg::SZ_W;
            3'd4: return rv_ctrl_pkg::SZ_BU;
            3'd5: return rv_ctrl_pkg::SZ_HU;
            default: return rv_ctrl_pkg::SZ_B;
        endcase
    endfunction

    // everything quiet while rst is low, whatever is applied
    task automatic test_reset();
        logic [31:0] w;
        for (int k = 0; k < RST_CYCLES; k++) begin
            w = lcg_next();
            // some loads and system ops among the random words
            if (k % 4 == 0) w[6:0] = rv_ctrl_pkg::OPC_LOAD;
            if (k % 4 == 2) w[6:0] = rv_ctrl_pkg::OPC_SYSTEM;
            drive(w, w[2:0]);
            check_ctrl("ctrl_o", ctrl, '0);
            check_wb("wb_o", wb, '0);
            check_crypto("crypto_o", crypto, '0);
            check_word("stall_o", {31'b0, stall}, 32'd0);
            check_word("sys_o", {31'b0, sys}, 32'd0);
            check_size("size_o", size, rv_ctrl_pkg::SZ_B);
        end
    endtask

    task automatic test_alu();
        logic [31:0] w;
        rv_ctrl_pkg::ctrl_t ec;
        rv_ctrl_pkg::wb_t ew;
        for (int k = 0; k < 40; k++) begin
            w = lcg_next();
            // r-type uses funct7 0 or 0100000 only
            if (k % 2 == 0) begin
                w[6:0] = rv_ctrl_pkg::OPC_ALU;
                w[31:25] = {1'b0, w[30], 5'b0};
            end else begin
                w[6:0] = rv_ctrl_pkg::OPC_IMM;
            end
            if (k % 5 == 0) w[11:7] = 5'd0;
            drive(w, 3'b000);
            ec = '0;
            ec.alu_func = exp_alu(w[14:12], w[30], k % 2 == 0);
            ec.mux_b_sel = (k % 2 != 0);
            ew.rd = w[11:7];
            ew.rd_sel = rv_ctrl_pkg::RD_ALU;
            ew.reg_we = (w[11:7] != 5'd0);
            check_ctrl("ctrl_o", ctrl, ec);
            check_wb("wb_o", wb, ew);
            check_word("rs1_o", {27'b0, rs1}, {27'b0, w[19:15]});
            check_word("rs2_o", {27'b0, rs2}, {27'b0, w[24:20]});
            check_word("sys_o", {31'b0, sys}, 32'd0);
            if (k % 2 != 0) check_word("imm_o", imm, imm_i(w));
        end
    endtask

    task automatic test_branch_jump();
        logic [31:0] w;
        logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        rv_ctrl_pkg::ctrl_t ec;
        rv_ctrl_pkg::wb_t ew;
        foreach (f3s[j]) begin
            for (int fl = 0; fl < 8; fl++) begin
                w = lcg_next();
                w = make_r(w[31:25], w[24:20], w[19:15], f3s[j], w[11:7],
                           rv_ctrl_pkg::OPC_BRANCH);
                drive(w, fl[2:0]);
                ec = '0;
                ec.alu_func = rv_ctrl_pkg::ALU_ADD;
                ec.pc_add_sel = exp_taken(f3s[j], fl[2:0]);
                ew = '{rd: w[11:7], rd_sel: rv_ctrl_pkg::RD_ALU, reg_we: 1'b0};
                check_ctrl("ctrl_o", ctrl, ec);
                check_wb("wb_o", wb, ew);
                check_word("imm_o", imm, imm_b(w));
            end
        end
        // jal, then jalr
        w = (lcg_next() & 32'hffff_f000) | 32'h0000_0280 | {25'b0, rv_ctrl_pkg::OPC_JAL};
        drive(w, 3'b000);
        ec = '0;
        ec.alu_func = rv_ctrl_pkg::ALU_ADD;
        ec.mux_a_sel = 1'b1;
        ec.mux_b_sel = 1'b1;
        ec.pc_add_sel = 1'b1;
        ec.jal_sel = 1'b1;
        check_ctrl("ctrl_o", ctrl, ec);
        check_wb("wb_o", wb, '{rd: 5'd5, rd_sel: rv_ctrl_pkg::RD_PC4, reg_we: 1'b1});
        check_word("imm_o", imm, imm_j(w));
        w = (lcg_next() & 32'hffff_8000) | 32'h0000_0080 | {25'b0, rv_ctrl_pkg::OPC_JALR};
        drive(w, 3'b000);
        ec = '0;
        ec.alu_func = rv_ctrl_pkg::ALU_ADD_JALR;
        ec.mux_b_sel = 1'b1;
        ec.pc_next_sel = 1'b1;
        ec.jal_sel = 1'b1;
        check_ctrl("ctrl_o", ctrl, ec);
        check_wb("wb_o", wb, '{rd: 5'd1, rd_sel: rv_ctrl_pkg::RD_PC4, reg_we: 1'b1});
        check_word("imm_o", imm, imm_i(w));
    endtask

    task automatic test_load();
        logic [31:0] w;
        logic [4:0] rd;
        logic [2:0] f3s [5] = '{3'd2, 3'd0, 3'd1, 3'd4, 3'd5};
        for (int k = 0; k < 10; k++) begin
            w = lcg_next();
            rd = (k % 5 == 3) ? 5'd0 : w[11:7];
            w = make_r(w[31:25], w[24:20], w[19:15], f3s[k % 5], rd, rv_ctrl_pkg::OPC_LOAD);
            drive(w, 3'b000);
            check_word("stall_o", {31'b0, stall}, 32'd1);
            check_wb("wb_o", wb, '{rd: rd, rd_sel: rv_ctrl_pkg::RD_ALU, reg_we: 1'b0});
            check_word("ctrl_o.load", {31'b0, ctrl.load}, 32'd1);
            // same word again while stalled
            drive(w, 3'b000);
            check_word("stall_o", {31'b0, stall}, 32'd0);
            check_wb("wb_o", wb, '{rd: rd, rd_sel: rv_ctrl_pkg::RD_LOAD, reg_we: rd != 5'd0});
            check_size("size_o", size, exp_size(f3s[k % 5]));
            drive(NOP, 3'b000);
            check_word("stall_o", {31'b0, stall}, 32'd0);
            check_wb("wb_o", wb, '{rd: 5'd0, rd_sel: rv_ctrl_pkg::RD_ALU, reg_we: 1'b0});
        end
    endtask

    task automatic test_store();
        logic [31:0] w;
        logic [2:0] f3s [3] = '{3'd2, 3'd0, 3'd1};
        rv_ctrl_pkg::ctrl_t ec;
        foreach (f3s[j]) begin
            w = lcg_next();
            w = make_r(w[31:25], w[24:20], w[19:15], f3s[j], w[11:7], rv_ctrl_pkg::OPC_STORE);
            drive(w, 3'b000);
            ec = '0;
            ec.alu_func = rv_ctrl_pkg::ALU_ADD;
            ec.mux_b_sel = 1'b1;
            ec.mem_we = 1'b1;
            ec.store = 1'b1;
            check_ctrl("ctrl_o", ctrl, ec);
            check_wb("wb_o", wb, '{rd: w[11:7], rd_sel: rv_ctrl_pkg::RD_ALU, reg_we: 1'b0});
            check_word("stall_o", {31'b0, stall}, 32'd0);
            check_word("imm_o", imm, imm_s(w));
            drive(NOP, 3'b000);
            check_size("size_o", size, exp_size(f3s[j]));
        end
    endtask

    task automatic test_sha();
        logic [31:0] w;
        rv_ctrl_pkg::crypto_t ex;
        for (int k = 0; k < 12; k++) begin
            w = lcg_next();
            w = make_r(7'b0001000, {3'b000, k[1:0]}, w[19:15], 3'b001, w[11:7],
                       rv_ctrl_pkg::OPC_IMM);
            // near misses: bit 28 cleared, or a bit of 24:22 set
            if (k >= 4 && k < 8) w[28] = 1'b0;
            if (k >= 8) w[22 + (k % 3)] = 1'b1;
            drive(w, 3'b000);
            ex.valid = (k < 4);
            ex.bs = w[31:30];
            ex.op = rv_ctrl_pkg::sha_op_e'(w[21:20]);
            check_crypto("crypto_o", crypto, ex);
        end
    endtask

    // u-type decode, then the system/fence flag
    task automatic test_upper_sys();
        logic [31:0] w;
        rv_ctrl_pkg::ctrl_t ec;
        ec = '0;
        ec.alu_func = rv_ctrl_pkg::ALU_ADD;
        ec.mux_a_sel = 1'b1;
        ec.mux_b_sel = 1'b1;
        // lui into x3
        w = (lcg_next() & 32'hffff_f000) | 32'h0000_0180 | {25'b0, rv_ctrl_pkg::OPC_LUI};
        drive(w, 3'b000);
        check_ctrl("ctrl_o", ctrl, ec);
        check_wb("wb_o", wb, '{rd: 5'd3, rd_sel: rv_ctrl_pkg::RD_IMM, reg_we: 1'b1});
        check_word("imm_o", imm, {w[31:12], 12'b0});
        check_word("sys_o", {31'b0, sys}, 32'd0);
        // auipc into x2
        w = (lcg_next() & 32'hffff_f000) | 32'h0000_0100 | {25'b0, rv_ctrl_pkg::OPC_AUIPC};
        drive(w, 3'b000);
        check_ctrl("ctrl_o", ctrl, ec);
        check_wb("wb_o", wb, '{rd: 5'd2, rd_sel: rv_ctrl_pkg::RD_ALU, reg_we: 1'b1});
        check_word("imm_o", imm, {w[31:12], 12'b0});
        // ecall, then fence
        drive(32'h0000_0073, 3'b000);
        check_word("sys_o", {31'b0, sys}, 32'd1);
        drive(32'h0ff0_000f, 3'b000);
        check_word("sys_o", {31'b0, sys}, 32'd1);
    endtask

    initial begin
        rst = 1'b0;
        instr = NOP;
        eq = 1'b0;
        lt = 1'b0;
        ltu = 1'b0;
        test_reset();
        @(negedge clk);
        rst = 1'b1;
        instr = NOP;
        test_alu();
        test_branch_jump();
        test_load();
        test_store();
        test_sha();
        test_upper_sys();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the rv_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_ctrl_tb -f rv_ctrl.f

out=$(./obj_dir/Vrv_ctrl_tb || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// File: rv_ctrl.f
verilog/rv_ctrl_pkg.sv
verilog/imm_gen.sv
verilog/op_decode.sv
verilog/mem_seq.sv
verilog/rv_ctrl.sv
dv/rv_ctrl_props.sv
dv/rv_ctrl_tb.sv

// File: verilog/imm_gen.sv
module imm_gen (
    input  rv_ctrl_pkg::insn_u           instr_i,
    output logic [rv_ctrl_pkg::XLEN-1:0] imm_o
);

    // raw fields, all through the i view
    logic [11:0] imm12;
    logic [4:0]  rd_f;
    // instruction bits 19:12
    logic [7:0]  mid8;
    logic        sign;

    assign imm12 = instr_i.i.imm12;
    assign rd_f  = instr_i.i.rd;
    assign mid8  = {instr_i.i.rs1, instr_i.i.funct3};
    // sign bit is always instruction bit 31
    assign sign  = imm12[11];

    always_comb begin
        case (instr_i.i.opcode)
            // u-format, upper 20 bits
            rv_ctrl_pkg::OPC_LUI,
            rv_ctrl_pkg::OPC_AUIPC: begin
                imm_o = {imm12, mid8, 12'b0};
            end
            // j-format, halfword offset
            rv_ctrl_pkg::OPC_JAL: begin
                imm_o = {{(rv_ctrl_pkg::XLEN-20){sign}}, mid8, imm12[0],
                         imm12[10:1], 1'b0};
            end
            // b-format, halfword offset
            rv_ctrl_pkg::OPC_BRANCH: begin
                imm_o = {{(rv_ctrl_pkg::XLEN-12){sign}}, rd_f[0], imm12[10:5],
                         rd_f[4:1], 1'b0};
            end
            // s-format, low bits live in the rd slot
            rv_ctrl_pkg::OPC_STORE: begin
                imm_o = {{(rv_ctrl_pkg::XLEN-12){sign}}, imm12[11:5], rd_f};
            end
            // i-format for jalr, loads, op-imm, system
            default: begin
                imm_o = {{(rv_ctrl_pkg::XLEN-12){sign}}, imm12};
            end
        endcase
    end

endmodule

// File: verilog/mem_seq.sv
module mem_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_ctrl_pkg::insn_u     instr_i,
    input  rv_ctrl_pkg::wb_t       dec_wb_i,
    input  rv_ctrl_pkg::ctrl_t     ctrl_i,
    output rv_ctrl_pkg::wb_t       wb_o,
    output logic                   stall_o,
    output rv_ctrl_pkg::mem_size_e size_o
);

    rv_ctrl_pkg::seq_state_e        state_q, state_d;
    // destination of the load in flight
    logic [rv_ctrl_pkg::REG_AW-1:0] ld_rd_q;
    rv_ctrl_pkg::mem_size_e         size_d;

    // first load cycle holds fetch
    assign stall_o = (state_q == rv_ctrl_pkg::ST_IDLE) && ctrl_i.load;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_ctrl_pkg::ST_IDLE: if (ctrl_i.load) state_d = rv_ctrl_pkg::ST_WB;
            // one writeback cycle, then back
            default: state_d = rv_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= rv_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_o) begin
            ld_rd_q <= dec_wb_i.rd;
        end
    end

    // funct3 to access size
    always_comb begin
        case (instr_i.r.funct3)
            3'b000:  size_d = rv_ctrl_pkg::SZ_B;
            3'b001:  size_d = rv_ctrl_pkg::SZ_H;
            3'b010:  size_d = rv_ctrl_pkg::SZ_W;
            3'b100:  size_d = rv_ctrl_pkg::SZ_BU;
            3'b101:  size_d = rv_ctrl_pkg::SZ_HU;
            default: size_d = rv_ctrl_pkg::SZ_B;
        endcase
    end

    // size only moves on a memory op
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            size_o <= rv_ctrl_pkg::SZ_B;
        end else if (ctrl_i.load || ctrl_i.store) begin
            size_o <= size_d;
        end
    end

    // wb state swaps in the delayed load writeback
    always_comb begin
        wb_o = dec_wb_i;
        if (state_q == rv_ctrl_pkg::ST_WB) begin
            wb_o.rd = ld_rd_q;
            wb_o.rd_sel = rv_ctrl_pkg::RD_LOAD;
            wb_o.reg_we = |ld_rd_q;
        end
    end

endmodule

// File: verilog/op_decode.sv
module op_decode (
    input  logic                 rst,
    input  rv_ctrl_pkg::insn_u   instr_i,
    input  logic                 eq_i,
    input  logic                 lt_i,
    input  logic                 ltu_i,
    output rv_ctrl_pkg::ctrl_t   ctrl_o,
    output rv_ctrl_pkg::wb_t     wb_o,
    output rv_ctrl_pkg::crypto_t crypto_o,
    output logic                 sys_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    // one-hot funct3
    logic [7:0] f3;
    // instruction bit 30, sub/sra select
    logic       alt;
    logic       is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic       is_load, is_store, is_imm, is_alu;
    logic       br_taken;
    logic       rd_nz;
    logic       sha_hit;
    rv_ctrl_pkg::alu_func_e alu_func;
    rv_ctrl_pkg::ctrl_t     ctrl_d;
    rv_ctrl_pkg::wb_t       wb_d;
    rv_ctrl_pkg::crypto_t   crypto_d;
    logic                   sys_d;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign funct7 = instr_i.r.funct7;
    assign f3     = 8'b1 << funct3;
    assign alt    = funct7[5];

    // opcode match
    assign is_lui    = (opcode == rv_ctrl_pkg::OPC_LUI);
    assign is_auipc  = (opcode == rv_ctrl_pkg::OPC_AUIPC);
    assign is_jal    = (opcode == rv_ctrl_pkg::OPC_JAL);
    assign is_jalr   = (opcode == rv_ctrl_pkg::OPC_JALR);
    assign is_branch = (opcode == rv_ctrl_pkg::OPC_BRANCH);
    assign is_load   = (opcode == rv_ctrl_pkg::OPC_LOAD);
    assign is_store  = (opcode == rv_ctrl_pkg::OPC_STORE);
    assign is_imm    = (opcode == rv_ctrl_pkg::OPC_IMM);
    assign is_alu    = (opcode == rv_ctrl_pkg::OPC_ALU);
    assign sys_d     = (opcode == rv_ctrl_pkg::OPC_SYSTEM) ||
                       (opcode == rv_ctrl_pkg::OPC_FENCE);

    // branch condition against the comparator flags
    // beq bne - - blt bge bltu bgeu
    assign br_taken = is_branch & ((f3[0] & eq_i) | (f3[1] & ~eq_i) |
                                   (f3[4] & lt_i) | (f3[5] & ~lt_i) |
                                   (f3[6] & ltu_i) | (f3[7] & ~ltu_i));

    // alu function, add unless op/op-imm/jalr say otherwise
    always_comb begin
        alu_func = rv_ctrl_pkg::ALU_ADD;
        if (is_jalr) begin
            alu_func = rv_ctrl_pkg::ALU_ADD_JALR;
        end else if (is_alu || is_imm) begin
            unique case (1'b1)
                // addi never subtracts
                f3[0]: alu_func = (is_alu && alt) ? rv_ctrl_pkg::ALU_SUB
                                                  : rv_ctrl_pkg::ALU_ADD;
                f3[1]: alu_func = rv_ctrl_pkg::ALU_SLL;
                f3[2]: alu_func = rv_ctrl_pkg::ALU_SLT;
                f3[3]: alu_func = rv_ctrl_pkg::ALU_SLTU;
                f3[4]: alu_func = rv_ctrl_pkg::ALU_XOR;
                // srai shares bit 30 with sra
                f3[5]: alu_func = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
                f3[6]: alu_func = rv_ctrl_pkg::ALU_OR;
                f3[7]: alu_func = rv_ctrl_pkg::ALU_AND;
                default: alu_func = rv_ctrl_pkg::ALU_ADD;
            endcase
        end
    end

    // operand and pc selects
    always_comb begin
        ctrl_d = '0;
        ctrl_d.alu_func = alu_func;
        // pc into operand a
        ctrl_d.mux_a_sel = is_jal | is_lui | is_auipc;
        // immediate into operand b
        ctrl_d.mux_b_sel = is_lui | is_auipc | is_jal | is_jalr |
                           is_load | is_store | is_imm;
        // pc + imm target
        ctrl_d.pc_add_sel = is_jal | br_taken;
        // rs1 + imm target
        ctrl_d.pc_next_sel = is_jalr;
        ctrl_d.jal_sel = is_jal | is_jalr;
        ctrl_d.mem_we = is_store;
        ctrl_d.store = is_store;
        ctrl_d.load = is_load;
    end

    // provisional writeback; loads are finished by the sequencer
    assign rd_nz = |instr_i.r.rd;

    always_comb begin
        wb_d.rd = instr_i.r.rd;
        wb_d.rd_sel = rv_ctrl_pkg::RD_ALU;
        if (is_lui) begin
            wb_d.rd_sel = rv_ctrl_pkg::RD_IMM;
        end else if (is_jal || is_jalr) begin
            wb_d.rd_sel = rv_ctrl_pkg::RD_PC4;
        end
        // x0 never written
        wb_d.reg_we = rd_nz & (is_lui | is_auipc | is_jal | is_jalr | is_alu | is_imm);
    end

    // sha-256 unary ops, funct7 = 0001000 and rs2[4:2] = 0
    assign sha_hit = is_imm && f3[rv_ctrl_pkg::F3_SHA] && funct7[3] &&
                     !(|{funct7[6:4], funct7[2:0]}) && !(|instr_i.r.rs2[4:2]);

    always_comb begin
        crypto_d.valid = sha_hit;
        crypto_d.bs = funct7[6:5];
        crypto_d.op = rv_ctrl_pkg::sha_op_e'(instr_i.i.imm12[1:0]);
    end

    // everything held at zero in reset
    assign ctrl_o   = rst ? ctrl_d : '0;
    assign wb_o     = rst ? wb_d : '0;
    assign crypto_o = rst ? crypto_d : '0;
    assign sys_o    = rst & sys_d;

endmodule

// File: verilog/rv_ctrl.sv
module rv_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  rv_ctrl_pkg::insn_u               instr_i,
    input  logic                             eq_i,
    input  logic                             lt_i,
    input  logic                             ltu_i,
    output logic [rv_ctrl_pkg::REG_AW-1:0]   rs1_o,
    output logic [rv_ctrl_pkg::REG_AW-1:0]   rs2_o,
    output logic [rv_ctrl_pkg::XLEN-1:0]     imm_o,
    output rv_ctrl_pkg::ctrl_t               ctrl_o,
    output rv_ctrl_pkg::wb_t                 wb_o,
    output rv_ctrl_pkg::mem_size_e           size_o,
    output rv_ctrl_pkg::crypto_t             crypto_o,
    output logic                             sys_o,
    output logic                             stall_o
);

    // writeback before the load sequencer
    rv_ctrl_pkg::wb_t dec_wb;

    // source registers straight from the r view
    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;

    imm_gen i_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm_o)
    );

    op_decode i_op_decode (
        .rst      (rst),
        .instr_i  (instr_i),
        .eq_i     (eq_i),
        .lt_i     (lt_i),
        .ltu_i    (ltu_i),
        .ctrl_o   (ctrl_o),
        .wb_o     (dec_wb),
        .crypto_o (crypto_o),
        .sys_o    (sys_o)
    );

    mem_seq i_mem_seq (
        .clk      (clk),
        .rst      (rst),
        .instr_i  (instr_i),
        .dec_wb_i (dec_wb),
        .ctrl_i   (ctrl_o),
        .wb_o     (wb_o),
        .stall_o  (stall_o),
        .size_o   (size_o)
    );

endmodule

// File: verilog/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // datapath and instruction width
    localparam int XLEN = 32;
    // register file address width
    localparam int REG_AW = 5;

    // major opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_ALU    = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    // sha-256 unary ops sit under op-imm with this funct3
    localparam logic [2:0] F3_SHA = 3'b001;

    // alu function codes as seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_SLL      = 4'd2,
        ALU_SLT      = 4'd3,
        ALU_SLTU     = 4'd4,
        ALU_XOR      = 4'd5,
        ALU_SRL      = 4'd6,
        ALU_SRA      = 4'd7,
        ALU_OR       = 4'd8,
        ALU_AND      = 4'd9,
        // add, then clear bit 0 of the target
        ALU_ADD_JALR = 4'd10
    } alu_func_e;

    // load/store access size, u = zero extend
    typedef enum logic [2:0] {
        SZ_B  = 3'd0,
        SZ_BU = 3'd1,
        SZ_H  = 3'd2,
        SZ_HU = 3'd3,
        SZ_W  = 3'd4
    } mem_size_e;

    // writeback source
    typedef enum logic [1:0] {
        RD_ALU  = 2'd0,
        RD_IMM  = 2'd1,
        RD_PC4  = 2'd2,
        RD_LOAD = 2'd3
    } rd_sel_e;

    // sha-256 op, straight from bits 21:20
    typedef enum logic [1:0] {
        SHA_SUM0 = 2'd0,
        SHA_SUM1 = 2'd1,
        SHA_SIG0 = 2'd2,
        SHA_SIG1 = 2'd3
    } sha_op_e;

    // load sequencer states
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WB   = 1'b1
    } seq_state_e;

    // r-type field layout
    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fields_t;

    // i-type field layout, also the base for s/b/u/j immediates
    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fields_t;

    // one instruction word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } insn_u;

    // execute and fetch controls
    typedef struct packed {
        alu_func_e alu_func;
        logic      mux_a_sel;
        logic      mux_b_sel;
        logic      pc_add_sel;
        logic      pc_next_sel;
        logic      jal_sel;
        logic      mem_we;
        logic      store;
        logic      load;
    } ctrl_t;

    // register writeback
    typedef struct packed {
        logic [REG_AW-1:0] rd;
        rd_sel_e           rd_sel;
        logic              reg_we;
    } wb_t;

    // crypto unit request
    typedef struct packed {
        logic       valid;
        logic [1:0] bs;
        sha_op_e    op;
    } crypto_t;

endpackage
